//--- fetch_1.f
+incdir+include
verilog/fetch_pkg.sv
verilog/fip_select.sv
verilog/itlb.sv
verilog/icache_bank.sv
verilog/fill_beat_counter.sv
verilog/fill_ctrl.sv
verilog/fetch_1.sv
verif/fetch_1_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f fetch_1.f \
		--top-module fetch_1_tb -o fetch_1_sim
	./obj_dir/fetch_1_sim

clean:
	rm -rf obj_dir

//--- verif/fetch_1_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_1_tb;

    localparam int MAX_CYCLES = 4000; // far beyond the few hundred cycles the tests need
    localparam int WAIT_LIMIT = 40;   // one refill with the longest beat gaps
    localparam int SIG_REQ    = 0;
    localparam int SIG_WR_E   = 1;
    localparam int SIG_WR_O   = 2;

    // page 3 maps to itself, page 5 is uncached, page 9 has no entry
    localparam logic [19:0] IDENT_VP  = 20'h00003;
    localparam logic [19:0] PCD_VP    = 20'h00005;
    localparam logic [31:0] INIT_ADDR = 32'h0000_0050; // line 5

    localparam fetch_pkg::line_addr_t INIT_LINE_E = 28'h6; // even bank moves up to line 6
    localparam fetch_pkg::line_addr_t INIT_LINE_O = 28'h5; // odd bank keeps line 5

    logic clk, rst_i;
    logic init_i, resteer_i, br_taken_i, ld_fip_e_i, ld_fip_o_i;
    logic [31:0] init_addr_i;
    fetch_pkg::line_addr_t wb_fip_e_i, wb_fip_o_i, bp_fip_e_i, bp_fip_o_i;
    logic [`FETCH_TLB_ENTRIES*`FETCH_VP_BITS-1:0] tlb_vp_i, tlb_pf_i;
    logic [`FETCH_TLB_ENTRIES-1:0] tlb_valid_i, tlb_present_i, tlb_pcd_i;
    logic mem_beat_i;
    logic [`FETCH_BEAT_BITS-1:0] mem_data_i;
    fetch_pkg::cache_line_t line_e_o, line_o_o;
    logic miss_e_o, miss_o_o, tlb_miss_e_o, tlb_miss_o_o, prot_fault_e_o, prot_fault_o_o;
    logic even_w_o, odd_w_o, mem_req_o;
    logic [1:0] fip_e_lsb_o, fip_o_lsb_o;
    fetch_pkg::pline_addr_t mem_addr_o;

    int unsigned cycles = 0;
    int unsigned lcg_state = 4879;

    fetch_1 dut (.*);

    ////////////////////
    // reference model

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // beat k of a memory line marked with the whole line address
    function automatic logic [31:0] beat_word(input fetch_pkg::pline_addr_t pl, input int k);
        return {8'hc3, 2'(k), pl, ~pl};
    endfunction

    function automatic fetch_pkg::cache_line_t model_line(input fetch_pkg::pline_addr_t pl);
        fetch_pkg::cache_line_t l;
        for (int k = 0; k < `FETCH_BEATS; k++) begin
            l[32*k +: 32] = beat_word(pl, k); // beat 0 in the low word
        end
        return l;
    endfunction

    // only called for lines of the identity page
    function automatic fetch_pkg::pline_addr_t phys_line(input fetch_pkg::line_addr_t va);
        return {IDENT_VP[2:0], va[7:0]};
    endfunction

    function automatic logic watched_level(input int which);
        case (which)
            SIG_REQ:  return mem_req_o;
            SIG_WR_E: return even_w_o;
            default:  return odd_w_o;
        endcase
    endfunction

    ////////////////////
    // checking

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("mismatch %s: got %0h expected %0h", name, got, exp));
    endtask

    task automatic check_lsbs(input fetch_pkg::line_addr_t e, input fetch_pkg::line_addr_t o);
        check_val("fip_e_lsb_o", fip_e_lsb_o, e[1:0]);
        check_val("fip_o_lsb_o", fip_o_lsb_o, o[1:0]);
    endtask

    // call at a falling edge
    task automatic wait_high(input int which, input string what);
        int n;
        n = 0;
        while (!watched_level(which) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (watched_level(which)) else stop_with_failure({"no ", what, " in time"});
    endtask

    // one refill from the request to the line landing in the bank
    task automatic expect_fill(input logic odd, input fetch_pkg::line_addr_t va);
        string wr_name [2];
        string sfx;
        wr_name[0] = "even_w_o";
        wr_name[1] = "odd_w_o";
        sfx = odd ? "o" : "e";
        wait_high(SIG_REQ, "memory request");
        check_val("mem_addr_o", mem_addr_o, phys_line(va));
        wait_high(odd ? SIG_WR_O : SIG_WR_E, "bank write strobe");
        check_val("mem_req_o", mem_req_o, 1'b0);
        check_val(wr_name[!odd], odd ? even_w_o : odd_w_o, 1'b0);
        @(negedge clk);
        check_val(wr_name[odd], odd ? odd_w_o : even_w_o, 1'b0); // single pulse
        check_val({"miss_", sfx, "_o"}, odd ? miss_o_o : miss_e_o, 1'b0);
        check_val({"line_", sfx, "_o"}, odd ? line_o_o : line_e_o, model_line(phys_line(va)));
    endtask

    task automatic expect_no_request(input int n);
        repeat (n) begin
            @(negedge clk);
            check_val("mem_req_o", mem_req_o, 1'b0);
        end
    endtask

    // hold both banks on predicted lines without decode loads
    task automatic park(input fetch_pkg::line_addr_t e, input fetch_pkg::line_addr_t o);
        @(posedge clk);
        br_taken_i <= 1'b1;
        bp_fip_e_i <= e;
        bp_fip_o_i <= o;
        @(negedge clk);
    endtask

    ////////////////////
    // clock, timeout, memory

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < MAX_CYCLES) else stop_with_failure("run exceeded the cycle limit");
    end

    initial begin : memory_model
        fetch_pkg::pline_addr_t addr;
        int unsigned gap;
        mem_beat_i <= 1'b0;
        mem_data_i <= '0;
        forever begin
            @(negedge clk);
            if (mem_req_o) begin
                addr = mem_addr_o;
                for (int k = 0; k < `FETCH_BEATS; k++) begin
                    gap = lcg_next() % 3; // idle cycles before this beat
                    repeat (gap) @(posedge clk);
                    @(posedge clk);
                    mem_beat_i <= 1'b1;
                    mem_data_i <= beat_word(addr, k);
                    @(posedge clk);
                    mem_beat_i <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // stimulus

    initial begin : stimulus
        fetch_pkg::line_addr_t exp_e;
        fetch_pkg::line_addr_t exp_o;
        rst_i         <= 1'b1;
        init_i        <= 1'b0;
        init_addr_i   <= '0;
        resteer_i     <= 1'b0;
        wb_fip_e_i    <= '0;
        wb_fip_o_i    <= '0;
        br_taken_i    <= 1'b0;
        bp_fip_e_i    <= '0;
        bp_fip_o_i    <= '0;
        ld_fip_e_i    <= 1'b0;
        ld_fip_o_i    <= 1'b0;
        tlb_vp_i      <= {{6{20'h0}}, PCD_VP, IDENT_VP};
        tlb_pf_i      <= {{6{20'h0}}, 20'h00006, IDENT_VP};
        tlb_valid_i   <= 8'b0000_0011;
        tlb_present_i <= 8'b0000_0011;
        tlb_pcd_i     <= 8'b0000_0010;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);

        // page 0 is unmapped so nothing is fetched after reset
        check_val("mem_req_o", mem_req_o, 1'b0);
        check_val("even_w_o", even_w_o, 1'b0);
        check_val("odd_w_o", odd_w_o, 1'b0);
        check_lsbs(28'd0, 28'd1);

        @(posedge clk);
        init_i      <= 1'b1;
        init_addr_i <= INIT_ADDR;
        @(negedge clk);
        check_lsbs(INIT_LINE_E, INIT_LINE_O);

        // priority among the control-flow strobes
        @(posedge clk);
        resteer_i  <= 1'b1;
        wb_fip_e_i <= 28'h20;
        wb_fip_o_i <= 28'h23;
        br_taken_i <= 1'b1;
        bp_fip_e_i <= 28'h32;
        bp_fip_o_i <= 28'h37;
        @(negedge clk);
        check_lsbs(INIT_LINE_E, INIT_LINE_O);
        @(posedge clk);
        init_i <= 1'b0;
        @(negedge clk);
        check_lsbs(28'h20, 28'h23);
        @(posedge clk);
        resteer_i <= 1'b0;
        @(negedge clk);
        check_lsbs(28'h32, 28'h37);

        // even miss only while odd sits on an unmapped page
        park(28'h310, 28'h001);
        check_val("miss_e_o", miss_e_o, 1'b1);
        check_val("miss_o_o", miss_o_o, 1'b0);
        check_val("mem_req_o", mem_req_o, 1'b0);
        @(negedge clk);
        check_val("mem_req_o", mem_req_o, 1'b1); // request follows the miss by one cycle
        expect_fill(1'b0, 28'h310);

        // both banks miss and even goes first
        park(28'h320, 28'h331);
        check_val("miss_e_o", miss_e_o, 1'b1);
        check_val("miss_o_o", miss_o_o, 1'b1);
        expect_fill(1'b0, 28'h320);
        expect_fill(1'b1, 28'h331);

        // filled lines hit
        park(28'h310, 28'h331);
        check_val("miss_e_o", miss_e_o, 1'b0);
        check_val("miss_o_o", miss_o_o, 1'b0);
        check_val("line_e_o", line_e_o, model_line(phys_line(28'h310)));
        expect_no_request(20);
        park(28'h320, 28'h331);
        check_val("miss_e_o", miss_e_o, 1'b0);
        check_val("line_e_o", line_e_o, model_line(phys_line(28'h320)));
        expect_no_request(5);

        // uncached and unmapped pages in both banks
        park(28'h500, 28'h901);
        check_val("prot_fault_e_o", prot_fault_e_o, 1'b1);
        check_val("tlb_miss_e_o", tlb_miss_e_o, 1'b0);
        check_val("tlb_miss_o_o", tlb_miss_o_o, 1'b1);
        check_val("prot_fault_o_o", prot_fault_o_o, 1'b0);
        check_val("miss_e_o", miss_e_o, 1'b0);
        check_val("miss_o_o", miss_o_o, 1'b0);
        expect_no_request(10);
        park(28'h900, 28'h501);
        check_val("tlb_miss_e_o", tlb_miss_e_o, 1'b1);
        check_val("prot_fault_o_o", prot_fault_o_o, 1'b1);
        check_val("miss_e_o", miss_e_o, 1'b0);
        check_val("miss_o_o", miss_o_o, 1'b0);
        expect_no_request(10);

        // decode loads with odd stopping partway
        @(posedge clk);
        bp_fip_e_i <= 28'h40;
        bp_fip_o_i <= 28'h51;
        ld_fip_e_i <= 1'b1;
        ld_fip_o_i <= 1'b1;
        exp_e = 28'h40;
        exp_o = 28'h51;
        @(negedge clk);
        check_lsbs(exp_e, exp_o);
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (ld_fip_e_i) begin
                exp_e = exp_e + 28'd2; // load taken on this edge
            end
            if (ld_fip_o_i) begin
                exp_o = exp_o + 28'd2;
            end
            br_taken_i <= 1'b0;
            ld_fip_o_i <= (i < 2);
            @(negedge clk);
            check_lsbs(exp_e, exp_o);
        end
        @(posedge clk);
        ld_fip_e_i <= 1'b0;
        ld_fip_o_i <= 1'b0;
        expect_no_request(5);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fetch_1.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_1 (
    input  wire                                         clk,
    input  wire                                         rst_i,

    input  wire                                         init_i,
    input  wire [31:0]                                  init_addr_i,
    input  wire                                         resteer_i,
    input  wire fetch_pkg::line_addr_t                  wb_fip_e_i,
    input  wire fetch_pkg::line_addr_t                  wb_fip_o_i,
    input  wire                                         br_taken_i,
    input  wire fetch_pkg::line_addr_t                  bp_fip_e_i,
    input  wire fetch_pkg::line_addr_t                  bp_fip_o_i,
    input  wire                                         ld_fip_e_i,   // decode took the even line
    input  wire                                         ld_fip_o_i,

    input  wire [`FETCH_TLB_ENTRIES*`FETCH_VP_BITS-1:0] tlb_vp_i,
    input  wire [`FETCH_TLB_ENTRIES*`FETCH_VP_BITS-1:0] tlb_pf_i,
    input  wire [`FETCH_TLB_ENTRIES-1:0]                tlb_valid_i,
    input  wire [`FETCH_TLB_ENTRIES-1:0]                tlb_present_i,
    input  wire [`FETCH_TLB_ENTRIES-1:0]                tlb_pcd_i,

    input  wire                                         mem_beat_i,
    input  wire [`FETCH_BEAT_BITS-1:0]                  mem_data_i,

    output fetch_pkg::cache_line_t                      line_e_o,
    output fetch_pkg::cache_line_t                      line_o_o,
    output logic                                        miss_e_o,
    output logic                                        miss_o_o,
    output logic                                        tlb_miss_e_o,
    output logic                                        tlb_miss_o_o,
    output logic                                        prot_fault_e_o,
    output logic                                        prot_fault_o_o,
    output logic                                        even_w_o,     // fill writing the even bank
    output logic                                        odd_w_o,
    output logic [1:0]                                  fip_e_lsb_o,
    output logic [1:0]                                  fip_o_lsb_o,
    output logic                                        mem_req_o,
    output fetch_pkg::pline_addr_t                      mem_addr_o
);

    fetch_pkg::line_addr_t  fip_e, fip_o;
    fetch_pkg::pline_addr_t pline_e, pline_o;
    fetch_pkg::pline_addr_t wr_pline;
    fetch_pkg::cache_line_t wr_line;
    logic                   lookup_e, lookup_o;
    logic                   cnt_clr, last_beat;

    ////////////////////
    // fetch addresses

    fip_select #(.PARITY(0)) u_sel_e (
        .clk(clk), .rst_i(rst_i),
        .init_i(init_i), .init_line_i(init_addr_i[31:4]),
        .resteer_i(resteer_i), .wb_fip_i(wb_fip_e_i),
        .br_taken_i(br_taken_i), .bp_fip_i(bp_fip_e_i),
        .ld_i(ld_fip_e_i), .fip_o(fip_e)
    );

    fip_select #(.PARITY(1)) u_sel_o (
        .clk(clk), .rst_i(rst_i),
        .init_i(init_i), .init_line_i(init_addr_i[31:4]),
        .resteer_i(resteer_i), .wb_fip_i(wb_fip_o_i),
        .br_taken_i(br_taken_i), .bp_fip_i(bp_fip_o_i),
        .ld_i(ld_fip_o_i), .fip_o(fip_o)
    );

    assign fip_e_lsb_o = fip_e[1:0];
    assign fip_o_lsb_o = fip_o[1:0];

    ////////////////////
    // translation

    itlb u_tlb_e (
        .va_line_i(fip_e), .tlb_vp_i(tlb_vp_i), .tlb_pf_i(tlb_pf_i),
        .tlb_valid_i(tlb_valid_i), .tlb_present_i(tlb_present_i), .tlb_pcd_i(tlb_pcd_i),
        .pline_o(pline_e), .miss_o(tlb_miss_e_o), .fault_o(prot_fault_e_o)
    );

    itlb u_tlb_o (
        .va_line_i(fip_o), .tlb_vp_i(tlb_vp_i), .tlb_pf_i(tlb_pf_i),
        .tlb_valid_i(tlb_valid_i), .tlb_present_i(tlb_present_i), .tlb_pcd_i(tlb_pcd_i),
        .pline_o(pline_o), .miss_o(tlb_miss_o_o), .fault_o(prot_fault_o_o)
    );

    assign lookup_e = !tlb_miss_e_o && !prot_fault_e_o;
    assign lookup_o = !tlb_miss_o_o && !prot_fault_o_o;

    ////////////////////
    // line banks

    icache_bank u_bank_e (
        .clk(clk), .rst_i(rst_i),
        .pline_i(pline_e), .lookup_i(lookup_e), .line_o(line_e_o), .miss_o(miss_e_o),
        .wr_i(even_w_o), .wr_pline_i(wr_pline), .wr_line_i(wr_line)
    );

    icache_bank u_bank_o (
        .clk(clk), .rst_i(rst_i),
        .pline_i(pline_o), .lookup_i(lookup_o), .line_o(line_o_o), .miss_o(miss_o_o),
        .wr_i(odd_w_o), .wr_pline_i(wr_pline), .wr_line_i(wr_line)
    );

    ////////////////////
    // refill

    fill_ctrl u_fill (
        .clk(clk), .rst_i(rst_i),
        .miss_e_i(miss_e_o), .miss_o_i(miss_o_o),
        .pline_e_i(pline_e), .pline_o_i(pline_o),
        .mem_beat_i(mem_beat_i), .mem_data_i(mem_data_i), .last_beat_i(last_beat),
        .cnt_clr_o(cnt_clr), .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
        .wr_e_o(even_w_o), .wr_o_o(odd_w_o),
        .wr_pline_o(wr_pline), .wr_line_o(wr_line)
    );

    fill_beat_counter u_beats (
        .clk(clk), .rst_i(rst_i),
        .clr_i(cnt_clr), .beat_i(mem_beat_i), .last_o(last_beat)
    );

endmodule

`default_nettype wire

//--- verilog/fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fill_ctrl (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire                           miss_e_i,
    input  wire                           miss_o_i,
    input  wire fetch_pkg::pline_addr_t   pline_e_i,
    input  wire fetch_pkg::pline_addr_t   pline_o_i,
    input  wire                           mem_beat_i,
    input  wire [`FETCH_BEAT_BITS-1:0]    mem_data_i,
    input  wire                           last_beat_i,
    output logic                          cnt_clr_o,
    output logic                          mem_req_o,
    output fetch_pkg::pline_addr_t        mem_addr_o,
    output logic                          wr_e_o,
    output logic                          wr_o_o,
    output fetch_pkg::pline_addr_t        wr_pline_o,
    output fetch_pkg::cache_line_t        wr_line_o
);

    localparam int LINE_W = `FETCH_LINE_BITS;
    localparam int BEAT_W = `FETCH_BEAT_BITS;

    fetch_pkg::fill_state_t state_q;
    fetch_pkg::pline_addr_t addr_q;
    fetch_pkg::cache_line_t line_q;
    logic                   odd_q;   // bank being filled
    logic                   start;

    assign start = (state_q == fetch_pkg::FILL_IDLE) && (miss_e_i || miss_o_i);

    ////////////////////
    // state machine

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= fetch_pkg::FILL_IDLE;
        end else begin
            unique case (state_q)
                fetch_pkg::FILL_IDLE: begin
                    if (start) begin
                        state_q <= fetch_pkg::FILL_REQ;
                    end
                end
                fetch_pkg::FILL_REQ: begin
                    if (last_beat_i) begin
                        state_q <= fetch_pkg::FILL_WRITE;
                    end
                end
                fetch_pkg::FILL_WRITE: begin
                    state_q <= fetch_pkg::FILL_IDLE; // miss drops once the line lands
                end
                default: begin
                    state_q <= fetch_pkg::FILL_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // address latch and beat assembly

    always_ff @(posedge clk) begin
        if (start) begin
            odd_q  <= ~miss_e_i;                       // even wins a tie
            addr_q <= miss_e_i ? pline_e_i : pline_o_i;
        end
        if ((state_q == fetch_pkg::FILL_REQ) && mem_beat_i) begin
            // shift in from the top, beat 0 ends up in bits 31:0
            line_q <= {mem_data_i, line_q[LINE_W-1:BEAT_W]};
        end
    end

    assign cnt_clr_o  = start;
    assign mem_req_o  = (state_q == fetch_pkg::FILL_REQ);
    assign mem_addr_o = addr_q;

    assign wr_e_o     = (state_q == fetch_pkg::FILL_WRITE) && !odd_q;
    assign wr_o_o     = (state_q == fetch_pkg::FILL_WRITE) && odd_q;
    assign wr_pline_o = addr_q;
    assign wr_line_o  = line_q;

endmodule

`default_nettype wire

//--- verilog/fill_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fill_beat_counter (
    input  wire  clk,
    input  wire  rst_i,
    input  wire  clr_i,   // new fill starting
    input  wire  beat_i,
    output logic last_o
);

    localparam int CNT_W = $clog2(`FETCH_BEATS);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst_i || clr_i) begin
            cnt_q <= '0;
        end else if (beat_i) begin
            cnt_q <= cnt_q + 1'b1; // wraps after the last beat
        end
    end

    // final beat of the line arriving now
    assign last_o = beat_i && (cnt_q == CNT_W'(`FETCH_BEATS - 1));

endmodule

`default_nettype wire

//--- verilog/icache_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module icache_bank (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire fetch_pkg::pline_addr_t pline_i,
    input  wire                         lookup_i,   // tlb hit, no fault
    output fetch_pkg::cache_line_t      line_o,
    output logic                        miss_o,
    input  wire                         wr_i,
    input  wire fetch_pkg::pline_addr_t wr_pline_i,
    input  wire fetch_pkg::cache_line_t wr_line_i
);

    localparam int SETS  = `FETCH_SETS;
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = $bits(fetch_pkg::pline_addr_t) - IDX_W - 1; // bit 0 is the bank

    logic [SETS-1:0]        valid_q;
    logic [TAG_W-1:0]       tag_q  [SETS];
    fetch_pkg::cache_line_t data_q [SETS];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    assign rd_idx = pline_i[IDX_W:1];
    assign rd_tag = pline_i[IDX_W+TAG_W:IDX_W+1];
    assign wr_idx = wr_pline_i[IDX_W:1];
    assign wr_tag = wr_pline_i[IDX_W+TAG_W:IDX_W+1];

    ////////////////////
    // read side

    assign line_o = data_q[rd_idx];
    assign miss_o = lookup_i && (!valid_q[rd_idx] || (tag_q[rd_idx] != rd_tag));

    ////////////////////
    // fill port

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0; // all sets empty
        end else if (wr_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= wr_line_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/itlb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module itlb (
    input  wire fetch_pkg::line_addr_t                          va_line_i,
    input  wire [`FETCH_TLB_ENTRIES*`FETCH_VP_BITS-1:0]         tlb_vp_i,
    input  wire [`FETCH_TLB_ENTRIES*`FETCH_VP_BITS-1:0]         tlb_pf_i,
    input  wire [`FETCH_TLB_ENTRIES-1:0]                        tlb_valid_i,
    input  wire [`FETCH_TLB_ENTRIES-1:0]                        tlb_present_i,
    input  wire [`FETCH_TLB_ENTRIES-1:0]                        tlb_pcd_i,
    output fetch_pkg::pline_addr_t                              pline_o,
    output logic                                                miss_o,
    output logic                                                fault_o
);

    localparam int N     = `FETCH_TLB_ENTRIES;
    localparam int VPW   = `FETCH_VP_BITS;
    localparam int LW    = $bits(fetch_pkg::line_addr_t);
    localparam int OFF_W = LW - VPW;                          // line bits inside a page
    localparam int PF_W  = $bits(fetch_pkg::pline_addr_t) - OFF_W;

    logic [N-1:0]    match;
    logic [PF_W-1:0] frame;

    // one compare per entry
    always_comb begin
        for (int i = 0; i < N; i++) begin
            match[i] = tlb_valid_i[i] && tlb_present_i[i] &&
                       (tlb_vp_i[i*VPW +: VPW] == va_line_i[LW-1:OFF_W]);
        end
    end

    // and-or pick, match is one-hot on a sane table
    always_comb begin
        frame = '0;
        for (int i = 0; i < N; i++) begin
            frame = frame | ({PF_W{match[i]}} & tlb_pf_i[i*VPW +: PF_W]);
        end
    end

    assign pline_o = {frame, va_line_i[OFF_W-1:0]};
    assign miss_o  = ~|match;
    assign fault_o = |(match & tlb_pcd_i); // uncached page, no fetch from it

endmodule

`default_nettype wire

//--- verilog/fip_select.sv
`timescale 1ns/1ps
`default_nettype none

module fip_select #(
    parameter int PARITY = 0 // 0 even bank, 1 odd bank
) (
    input  wire                        clk,
    input  wire                        rst_i,
    input  wire                        init_i,
    input  wire fetch_pkg::line_addr_t init_line_i,
    input  wire                        resteer_i,
    input  wire fetch_pkg::line_addr_t wb_fip_i,
    input  wire                        br_taken_i,
    input  wire fetch_pkg::line_addr_t bp_fip_i,
    input  wire                        ld_i,
    output fetch_pkg::line_addr_t      fip_o
);

    localparam logic PAR_BIT = 1'(PARITY);

    fetch_pkg::line_addr_t init_own;  // init line moved onto this bank
    fetch_pkg::line_addr_t cf_addr;
    fetch_pkg::line_addr_t fip_q;
    logic                  is_cf;

    // L if its lsb already matches, else the next line
    assign init_own = (init_line_i[0] == PAR_BIT) ? init_line_i : init_line_i + 28'd1;

    ////////////////////
    // control-flow priority

    always_comb begin
        if (init_i) begin
            cf_addr = init_own;
        end else if (resteer_i) begin
            cf_addr = wb_fip_i;
        end else begin
            cf_addr = bp_fip_i; // only meaningful with br_taken_i
        end
    end

    assign is_cf = init_i | resteer_i | br_taken_i;
    assign fip_o = is_cf ? cf_addr : fip_q;

    ////////////////////
    // advancing fetch register

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fip_q <= 28'(PARITY);
        end else if (ld_i) begin
            fip_q <= fip_o + 28'd2; // next line of the same parity
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // virtual line address, addr[31:4]
    typedef logic [27:0] line_addr_t;

    // physical line: {frame[2:0], va[11:4]}
    // bit 0 bank, [4:1] set, [10:5] tag
    typedef logic [10:0] pline_addr_t;

    typedef logic [`FETCH_LINE_BITS-1:0] cache_line_t;

    // refill sequencing
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,   // memory request up, collecting beats
        FILL_WRITE  // line complete, write strobe out
    } fill_state_t;

endpackage

`default_nettype wire

//--- include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////
// line and beat sizes

`define FETCH_LINE_BITS 128 // one cache line
`define FETCH_BEAT_BITS 32  // one memory beat
`define FETCH_BEATS     4   // beats per line

////////////////////
// array sizes

`define FETCH_SETS        16 // lines per bank
`define FETCH_TLB_ENTRIES 8
`define FETCH_VP_BITS     20 // virtual page number

`endif
